/* rtl/ecc_pkg.sv */
package ecc_pkg;

  // ------------------------------------------------------------
  // request and response encodings
  // ------------------------------------------------------------

  // host request opcode, one bit wide on the wire
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } mem_op_e;

  // read result, a double-bit error in any slice outranks a corrected one
  typedef enum logic [1:0] {
    ST_OK            = 2'd0,
    ST_CORRECTED     = 2'd1,
    ST_UNCORRECTABLE = 2'd2
  } rd_status_e;

  // ------------------------------------------------------------
  // SECDED code helpers
  // ------------------------------------------------------------

  // smallest hamming count r with 2**r >= width + r + 1, plus the overall parity bit
  function automatic int secded_bits(int width);
    int r;
    r = 1;
    while ((1 << r) < width + r + 1) begin
      r = r + 1;
    end
    return r + 1;
  endfunction

  // codeword position of data bit idx, powers of two are skipped since the
  // hamming bits sit there, so data bit 0 lands on position 3
  function automatic int secded_pos(int idx);
    int pos;
    int cnt;
    pos = 2;
    cnt = -1;
    while (cnt < idx) begin
      pos = pos + 1;
      if ((pos & (pos - 1)) != 0) begin
        cnt = cnt + 1;
      end
    end
    return pos;
  endfunction

endpackage

/* rtl/mem_port_if.sv */
`timescale 1ns/1ps

// access port between the request controller and the ECC memory bank
interface mem_port_if #(
  parameter int DWIDTH = 32,
  parameter int ADDR_W = 6
);
  import ecc_pkg::*;

  // one access per cycle while en is high
  logic              en;
  mem_op_e           we;
  logic [ADDR_W-1:0] addr;
  logic [DWIDTH-1:0] wdata;

  // read return, rvalid comes two cycles after the read access
  logic              rvalid;
  logic [DWIDTH-1:0] rdata;
  // flags are only meaningful while rvalid is high
  logic              err_sb;
  logic              err_mb;

  modport ctrl (
    output en, we, addr, wdata,
    input  rvalid, rdata, err_sb, err_mb
  );

  modport bank (
    input  en, we, addr, wdata,
    output rvalid, rdata, err_sb, err_mb
  );

endinterface

/* rtl/ecc_gen.sv */
`timescale 1ns/1ps

// SECDED check-bit generator for one data slice
module ecc_gen #(
  parameter int DATA_WIDTH = 16,
  parameter int ECC_WIDTH  = 6
) (
  input  logic [DATA_WIDTH-1:0] d,
  output logic [ECC_WIDTH-1:0]  ecc
);
  import ecc_pkg::*;

  // all check bits but the top one are hamming bits
  localparam int HW = ECC_WIDTH - 1;

  logic [HW-1:0] ham;
  logic          overall;

  // ------------------------------------------------------------
  // hamming bits
  // ------------------------------------------------------------

  // hamming bit j covers every data bit whose codeword position has bit j set
  always_comb begin
    ham = '0;
    for (int i = 0; i < DATA_WIDTH; i++) begin
      for (int j = 0; j < HW; j++) begin
        if (((secded_pos(i) >> j) & 1) != 0) begin
          ham[j] = ham[j] ^ d[i];
        end
      end
    end
  end

  // overall parity spans data and hamming bits, this is what tells a
  // single error apart from a double error in the checker
  assign overall = ^{d, ham};

  // parity bit sits above the hamming bits
  assign ecc = {overall, ham};

endmodule

/* rtl/ecc_check.sv */
`timescale 1ns/1ps

// SECDED checker for one slice, corrects one flipped bit and detects two
module ecc_check #(
  parameter int DATA_WIDTH = 16,
  parameter int ECC_WIDTH  = 6
) (
  input  logic [DATA_WIDTH-1:0] din,
  input  logic [ECC_WIDTH-1:0]  ecc,
  output logic [DATA_WIDTH-1:0] dout,
  output logic                  error_sb,
  output logic                  error_mb
);
  import ecc_pkg::*;

  localparam int HW = ECC_WIDTH - 1;

  logic [HW-1:0] ham_calc;
  logic [HW-1:0] syndrome;
  logic          parity_odd;
  logic          syn_nz;

  // ------------------------------------------------------------
  // syndrome
  // ------------------------------------------------------------

  // same coverage as the generator, recomputed from the stored data
  always_comb begin
    ham_calc = '0;
    for (int i = 0; i < DATA_WIDTH; i++) begin
      for (int j = 0; j < HW; j++) begin
        if (((secded_pos(i) >> j) & 1) != 0) begin
          ham_calc[j] = ham_calc[j] ^ din[i];
        end
      end
    end
  end

  // the syndrome equals the codeword position of a single flipped bit
  assign syndrome = ham_calc ^ ecc[HW-1:0];
  assign syn_nz   = |syndrome;

  // the whole received codeword has even parity when it is clean
  // or when an even number of bits flipped
  assign parity_odd = ^{din, ecc};

  // ------------------------------------------------------------
  // classification and correction
  // ------------------------------------------------------------

  // odd parity means one bit flipped, it may be a data bit, a hamming bit
  // or the parity bit itself (zero syndrome in that last case)
  assign error_sb = parity_odd;

  // even parity with a nonzero syndrome can only be two flipped bits
  assign error_mb = !parity_odd && syn_nz;

  // flip the data bit the syndrome points at, a syndrome that points at a
  // check bit matches no data position and leaves the data as it is
  always_comb begin
    dout = din;
    if (error_sb) begin
      for (int i = 0; i < DATA_WIDTH; i++) begin
        if (int'(syndrome) == secded_pos(i)) begin
          dout[i] = ~din[i];
        end
      end
    end
  end

endmodule

/* rtl/ecc_wrap.sv */
`timescale 1ns/1ps

// splits a memory word into ECC slices, adds check bits on the write side
// and checks and corrects each slice on the read side
module ecc_wrap #(
  parameter int DWIDTH   = 32,
  parameter int ECNT     = 2,
  parameter int EWIDTH   = 6,
  localparam int TWIDTH  = DWIDTH + (ECNT * EWIDTH)
) (
  input  logic [DWIDTH-1:0] wdata_in,
  output logic [TWIDTH-1:0] wdata_out,
  input  logic [TWIDTH-1:0] rdata_in,
  output logic [DWIDTH-1:0] rdata_out,
  input  logic              cfg_errinj_sb,
  input  logic              cfg_errinj_mb,
  output logic              error_sb,
  output logic              error_mb
);

  // slice width, rounded up so the slices cover the whole word
  localparam int PWIDTH = (DWIDTH + ECNT - 1) / ECNT;
  localparam int PADW   = ECNT * PWIDTH;

  logic [PADW-1:0]        wpad;
  logic [PADW-1:0]        rpad;
  logic [PADW-1:0]        cpad;
  logic [PADW-1:0]        gen_d;
  logic [ECNT*EWIDTH-1:0] gen_ecc;
  logic [ECNT-1:0]        slice_sb;
  logic [ECNT-1:0]        slice_mb;

  // pad bits are zero on both sides, so they never show up in a syndrome
  assign wpad = PADW'(wdata_in);
  assign rpad = PADW'(rdata_in[DWIDTH-1:0]);

  // error injection only corrupts what slice 0's generator sees,
  // the stored data stays as written and the mismatch shows up on the read
  always_comb begin
    gen_d    = wpad;
    gen_d[0] = wpad[0] ^ (cfg_errinj_sb | cfg_errinj_mb);
    gen_d[1] = wpad[1] ^ cfg_errinj_mb;
  end

  for (genvar g = 0; g < ECNT; g++) begin : g_slice
    ecc_gen #(
      .DATA_WIDTH (PWIDTH),
      .ECC_WIDTH  (EWIDTH)
    ) u_gen (
      .d   (gen_d[g*PWIDTH +: PWIDTH]),
      .ecc (gen_ecc[g*EWIDTH +: EWIDTH])
    );

    // slice g's check bits are stored at DWIDTH + g*EWIDTH
    ecc_check #(
      .DATA_WIDTH (PWIDTH),
      .ECC_WIDTH  (EWIDTH)
    ) u_check (
      .din      (rpad[g*PWIDTH +: PWIDTH]),
      .ecc      (rdata_in[DWIDTH + g*EWIDTH +: EWIDTH]),
      .dout     (cpad[g*PWIDTH +: PWIDTH]),
      .error_sb (slice_sb[g]),
      .error_mb (slice_mb[g])
    );
  end

  // codeword layout is check bits above the raw data
  assign wdata_out = {gen_ecc, wdata_in};
  assign rdata_out = cpad[DWIDTH-1:0];

  // any slice raising a flag flags the whole word
  assign error_sb = |slice_sb;
  assign error_mb = |slice_mb;

endmodule

/* rtl/ecc_sram.sv */
`timescale 1ns/1ps

// single-port codeword RAM with a registered read port
module ecc_sram #(
  parameter int WIDTH  = 44,
  parameter int ADDR_W = 6
) (
  input  logic              clk,
  input  logic              en,
  input  logic              we,
  input  logic [ADDR_W-1:0] addr,
  input  logic [WIDTH-1:0]  wdata,
  output logic [WIDTH-1:0]  rdata
);

  localparam int DEPTH = 1 << ADDR_W;

  logic [WIDTH-1:0] mem [DEPTH];

  // a write leaves rdata holding the previous read
  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        mem[addr] <= wdata;
      end else begin
        rdata <= mem[addr];
      end
    end
  end

endmodule

/* rtl/ecc_mem_bank.sv */
`timescale 1ns/1ps

// ECC memory bank, codeword RAM plus the SECDED wrapper around it
module ecc_mem_bank #(
  parameter int DWIDTH = 32,
  parameter int ECNT   = 2,
  parameter int EWIDTH = 6,
  parameter int ADDR_W = 6
) (
  input  logic     clk,
  input  logic     rst,
  mem_port_if.bank port,
  input  logic     cfg_errinj_sb,
  input  logic     cfg_errinj_mb
);
  import ecc_pkg::*;

  localparam int TWIDTH = DWIDTH + (ECNT * EWIDTH);

  logic [TWIDTH-1:0] code_wr;
  logic [TWIDTH-1:0] code_rd;
  logic [DWIDTH-1:0] data_fix;
  logic              fix_sb;
  logic              fix_mb;
  logic              ram_we;
  // RAM output for a read is valid in the cycle after the access
  logic              rd_d1;

  assign ram_we = (port.we == OP_WRITE);

  ecc_wrap #(
    .DWIDTH (DWIDTH),
    .ECNT   (ECNT),
    .EWIDTH (EWIDTH)
  ) u_wrap (
    .wdata_in      (port.wdata),
    .wdata_out     (code_wr),
    .rdata_in      (code_rd),
    .rdata_out     (data_fix),
    .cfg_errinj_sb (cfg_errinj_sb),
    .cfg_errinj_mb (cfg_errinj_mb),
    .error_sb      (fix_sb),
    .error_mb      (fix_mb)
  );

  ecc_sram #(
    .WIDTH  (TWIDTH),
    .ADDR_W (ADDR_W)
  ) u_sram (
    .clk   (clk),
    .en    (port.en),
    .we    (ram_we),
    .addr  (port.addr),
    .wdata (code_wr),
    .rdata (code_rd)
  );

  // two-stage valid pipe, access in t, RAM out in t+1, result in t+2
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_d1       <= 1'b0;
      port.rvalid <= 1'b0;
    end else begin
      rd_d1       <= port.en && !ram_we;
      port.rvalid <= rd_d1;
    end
  end

  // the checker sits between the RAM output and this register
  always_ff @(posedge clk) begin
    if (rd_d1) begin
      port.rdata  <= data_fix;
      port.err_sb <= fix_sb;
      port.err_mb <= fix_mb;
    end
  end

endmodule

/* rtl/ecc_mem_ctrl.sv */
`timescale 1ns/1ps

// request queue with credit return, issue to the bank and read response
module ecc_mem_ctrl #(
  parameter int DWIDTH    = 32,
  parameter int ADDR_W    = 6,
  parameter int REQ_DEPTH = 4,
  parameter int CNT_W     = 16
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                req_valid,
  input  ecc_pkg::mem_op_e    req_op,
  input  logic [ADDR_W-1:0]   req_addr,
  input  logic [DWIDTH-1:0]   req_wdata,
  output logic                credit_return,
  output logic                rsp_valid,
  output logic [DWIDTH-1:0]   rsp_data,
  output ecc_pkg::rd_status_e rsp_status,
  output logic [CNT_W-1:0]    sb_count,
  output logic [CNT_W-1:0]    mb_count,
  mem_port_if.ctrl            port
);
  import ecc_pkg::*;

  localparam int PTR_W = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
  localparam int QCNT_W = $clog2(REQ_DEPTH + 1);

  mem_op_e           q_op    [REQ_DEPTH];
  logic [ADDR_W-1:0] q_addr  [REQ_DEPTH];
  logic [DWIDTH-1:0] q_wdata [REQ_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [QCNT_W-1:0] q_count;
  logic              issue;
  rd_status_e        status_next;

  // pointers wrap at REQ_DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] p);
    if (int'(p) == REQ_DEPTH - 1) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  // ------------------------------------------------------------
  // request queue and issue
  // ------------------------------------------------------------

  // the bank takes an access every cycle, so the head goes out whenever
  // the queue is not empty and its credit goes back in the same cycle
  assign issue         = (q_count != '0);
  assign credit_return = issue;
  assign port.en       = issue;
  assign port.we       = q_op[rd_ptr];
  assign port.addr     = q_addr[rd_ptr];
  assign port.wdata    = q_wdata[rd_ptr];

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      q_count <= '0;
    end else begin
      if (req_valid) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (issue) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      // credits keep the host from pushing into a full queue
      case ({req_valid, issue})
        2'b10:   q_count <= q_count + 1'b1;
        2'b01:   q_count <= q_count - 1'b1;
        default: q_count <= q_count;
      endcase
    end
  end

  // queue entries hold payload only
  always_ff @(posedge clk) begin
    if (req_valid) begin
      q_op[wr_ptr]    <= req_op;
      q_addr[wr_ptr]  <= req_addr;
      q_wdata[wr_ptr] <= req_wdata;
    end
  end

  // ------------------------------------------------------------
  // response and error counters
  // ------------------------------------------------------------

  // double-bit error wins over a corrected slice elsewhere in the word
  assign status_next = port.err_mb ? ST_UNCORRECTABLE :
                       port.err_sb ? ST_CORRECTED : ST_OK;

  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_valid <= 1'b0;
      sb_count  <= '0;
      mb_count  <= '0;
    end else begin
      rsp_valid <= port.rvalid;
      // counters saturate at all ones
      if (port.rvalid && port.err_mb && mb_count != '1) begin
        mb_count <= mb_count + 1'b1;
      end
      if (port.rvalid && !port.err_mb && port.err_sb && sb_count != '1) begin
        sb_count <= sb_count + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (port.rvalid) begin
      rsp_data   <= port.rdata;
      rsp_status <= status_next;
    end
  end

endmodule

/* rtl/ecc_mem_top.sv */
`timescale 1ns/1ps

// ECC-protected memory subsystem, controller and bank joined by one port
module ecc_mem_top #(
  parameter int DWIDTH    = 32,
  parameter int ECNT      = 2,
  // check bits for one slice of the rounded-up slice width
  parameter int EWIDTH    = ecc_pkg::secded_bits((DWIDTH + ECNT - 1) / ECNT),
  parameter int ADDR_W    = 6,
  parameter int REQ_DEPTH = 4,
  parameter int CNT_W     = 16
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                req_valid,
  input  ecc_pkg::mem_op_e    req_op,
  input  logic [ADDR_W-1:0]   req_addr,
  input  logic [DWIDTH-1:0]   req_wdata,
  output logic                credit_return,
  output logic                rsp_valid,
  output logic [DWIDTH-1:0]   rsp_data,
  output ecc_pkg::rd_status_e rsp_status,
  output logic [CNT_W-1:0]    sb_count,
  output logic [CNT_W-1:0]    mb_count,
  input  logic                cfg_errinj_sb,
  input  logic                cfg_errinj_mb
);

  mem_port_if #(
    .DWIDTH (DWIDTH),
    .ADDR_W (ADDR_W)
  ) mem_port ();

  ecc_mem_ctrl #(
    .DWIDTH    (DWIDTH),
    .ADDR_W    (ADDR_W),
    .REQ_DEPTH (REQ_DEPTH),
    .CNT_W     (CNT_W)
  ) u_ctrl (
    .clk           (clk),
    .rst           (rst),
    .req_valid     (req_valid),
    .req_op        (req_op),
    .req_addr      (req_addr),
    .req_wdata     (req_wdata),
    .credit_return (credit_return),
    .rsp_valid     (rsp_valid),
    .rsp_data      (rsp_data),
    .rsp_status    (rsp_status),
    .sb_count      (sb_count),
    .mb_count      (mb_count),
    .port          (mem_port.ctrl)
  );

  // injection controls go straight to the bank's write encoder
  ecc_mem_bank #(
    .DWIDTH (DWIDTH),
    .ECNT   (ECNT),
    .EWIDTH (EWIDTH),
    .ADDR_W (ADDR_W)
  ) u_bank (
    .clk           (clk),
    .rst           (rst),
    .port          (mem_port.bank),
    .cfg_errinj_sb (cfg_errinj_sb),
    .cfg_errinj_mb (cfg_errinj_mb)
  );

endmodule

/* verif/tb_clkgen.sv */
`timescale 1ns/1ps

// free-running testbench clock, starts low so the first edge is a rising one
module tb_clkgen #(
  parameter int PERIOD_NS = 8
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always begin
    #(PERIOD_NS / 2) clk = ~clk;
  end

endmodule

/* verif/tb_ecc_mem.sv */
`timescale 1ns/1ps

// directed testbench for the ECC memory subsystem
module tb_ecc_mem;
  import ecc_pkg::*;

  localparam int DWIDTH     = 32;
  localparam int ADDR_W     = 6;
  localparam int REQ_DEPTH  = 4;
  localparam int CNT_W      = 16;
  localparam int CLK_NS     = 8;
  localparam int RST_CYCLES = 16;
  localparam int N_RT       = 16;
  localparam int N_BURST    = 12;
  // an idle queue drains any single request well inside this many cycles
  localparam int REQ_CYCLES = 8;
  localparam int RUN_CYCLES = RST_CYCLES + (2 * N_RT + 6 + N_BURST) * REQ_CYCLES;
  localparam int MARGIN     = 4;
  localparam int DRAIN_MAX  = 32;

  logic              clk;
  logic              rst;
  logic              req_valid;
  mem_op_e           req_op;
  logic [ADDR_W-1:0] req_addr;
  logic [DWIDTH-1:0] req_wdata;
  logic              credit_return;
  logic              rsp_valid;
  logic [DWIDTH-1:0] rsp_data;
  rd_status_e        rsp_status;
  logic [CNT_W-1:0]  sb_count;
  logic [CNT_W-1:0]  mb_count;
  logic              cfg_errinj_sb;
  logic              cfg_errinj_mb;

  // host side state holds the credits in hand and the count of negedges seen
  int credits;
  int cycle;
  int rsp_cycle;
  int errors;
  int tests_failed;

  // reference memory holds the expected read data and status per address
  logic [DWIDTH-1:0] ref_data [1 << ADDR_W];
  rd_status_e        ref_stat [1 << ADDR_W];
  logic [ADDR_W-1:0] used_addr [$];
  logic [DWIDTH-1:0] exp_data_q [$];
  rd_status_e        exp_stat_q [$];

  tb_clkgen #(.PERIOD_NS(CLK_NS)) u_clk (.clk(clk));

  ecc_mem_top dut (
    .clk           (clk),
    .rst           (rst),
    .req_valid     (req_valid),
    .req_op        (req_op),
    .req_addr      (req_addr),
    .req_wdata     (req_wdata),
    .credit_return (credit_return),
    .rsp_valid     (rsp_valid),
    .rsp_data      (rsp_data),
    .rsp_status    (rsp_status),
    .sb_count      (sb_count),
    .mb_count      (mb_count),
    .cfg_errinj_sb (cfg_errinj_sb),
    .cfg_errinj_mb (cfg_errinj_mb)
  );

  // ------------------------------------------------------------
  // host helpers
  // ------------------------------------------------------------

  // advance to the next falling edge and sample every output there
  // the same process drives the inputs right after, so nothing races
  task automatic tick();
    logic [DWIDTH-1:0] exp_d;
    rd_status_e        exp_s;
    @(negedge clk);
    cycle++;
    if (credit_return) begin
      credits++;
    end
    assert (credits <= REQ_DEPTH) else begin
      $display("ERROR at %0t: more credits came back than the host spent", $time);
      errors++;
    end
    if (rsp_valid) begin
      rsp_cycle = cycle;
      if (exp_data_q.size() == 0) begin
        $display("ERROR at %0t: response arrived with no read outstanding", $time);
        errors++;
      end else begin
        exp_d = exp_data_q.pop_front();
        exp_s = exp_stat_q.pop_front();
        assert (rsp_data == exp_d) else begin
          $display("MISMATCH at %0t: rsp_data %h, expected %h", $time, rsp_data, exp_d);
          errors++;
        end
        assert (rsp_status == exp_s) else begin
          $display("MISMATCH at %0t: rsp_status %s, expected %s", $time,
                   rsp_status.name(), exp_s.name());
          errors++;
        end
      end
    end
  endtask

  // sends one request once a credit is in hand and spends that credit
  task automatic send(mem_op_e op, logic [ADDR_W-1:0] addr, logic [DWIDTH-1:0] data);
    while (credits == 0) begin
      tick();
    end
    req_valid = 1'b1;
    req_op    = op;
    req_addr  = addr;
    req_wdata = data;
    credits--;
    // reads leave the queue in order, so the model state right now is what they return
    if (op == OP_READ) begin
      exp_data_q.push_back(ref_data[addr]);
      exp_stat_q.push_back(ref_stat[addr]);
    end
    tick();
    req_valid = 1'b0;
  endtask

  // wait until every credit is home and every read has answered
  task automatic drain();
    int n;
    n = 0;
    while ((credits != REQ_DEPTH || exp_data_q.size() != 0) && n < DRAIN_MAX) begin
      tick();
      n++;
    end
    if (credits != REQ_DEPTH || exp_data_q.size() != 0) begin
      $display("ERROR at %0t: requests still outstanding after %0d cycles", $time, n);
      errors++;
    end
  endtask

  // writes one word and holds the inject inputs up until the RAM write
  task automatic write_word(logic [ADDR_W-1:0] addr, logic [DWIDTH-1:0] data,
                            logic inj_sb, logic inj_mb);
    logic [DWIDTH-1:0] exp_val;
    exp_val = data;
    cfg_errinj_sb = inj_sb;
    cfg_errinj_mb = inj_mb;
    send(OP_WRITE, addr, data);
    // a single injected flip is corrected into the stored word, so bit 0 reads back
    // inverted, and a double flip is only detected, so the word reads back as written
    if (inj_mb) begin
      ref_stat[addr] = ST_UNCORRECTABLE;
    end else if (inj_sb) begin
      exp_val[0]     = ~data[0];
      ref_stat[addr] = ST_CORRECTED;
    end else begin
      ref_stat[addr] = ST_OK;
    end
    ref_data[addr] = exp_val;
    drain();
    // the write is issued in this cycle and lands on the next rising edge
    tick();
    cfg_errinj_sb = 1'b0;
    cfg_errinj_mb = 1'b0;
  endtask

  task automatic report_test(string name, int errors_before);
    if (errors == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - errors_before);
      tests_failed++;
    end
  endtask

  // ------------------------------------------------------------
  // tests
  // ------------------------------------------------------------

  task automatic test_round_trip();
    int e0;
    logic [ADDR_W-1:0] a;
    e0 = errors;
    for (int i = 0; i < N_RT; i++) begin
      a = ADDR_W'($urandom % (1 << ADDR_W));
      write_word(a, $urandom, 1'b0, 1'b0);
      used_addr.push_back(a);
    end
    foreach (used_addr[i]) begin
      send(OP_READ, used_addr[i], '0);
    end
    drain();
    assert (sb_count == '0 && mb_count == '0) else begin
      $display("MISMATCH at %0t: counters sb %0d mb %0d, expected 0", $time,
               sb_count, mb_count);
      errors++;
    end
    report_test("round_trip", e0);
  endtask

  task automatic test_inject(logic dbl);
    int e0;
    logic [ADDR_W-1:0] a;
    logic [CNT_W-1:0]  sb0;
    logic [CNT_W-1:0]  mb0;
    e0  = errors;
    sb0 = sb_count;
    mb0 = mb_count;
    a   = ADDR_W'($urandom % (1 << ADDR_W));
    write_word(a, $urandom, !dbl, dbl);
    send(OP_READ, a, '0);
    drain();
    // exactly one of the two counters moves up by one
    assert (sb_count == sb0 + CNT_W'(!dbl) && mb_count == mb0 + CNT_W'(dbl)) else begin
      $display("MISMATCH at %0t: counters sb %0d mb %0d, were sb %0d mb %0d", $time,
               sb_count, mb_count, sb0, mb0);
      errors++;
    end
    report_test(dbl ? "double_bit_inject" : "single_bit_inject", e0);
  endtask

  task automatic test_latency();
    int e0;
    int c0;
    int lat;
    e0 = errors;
    drain();
    c0 = cycle;
    send(OP_READ, used_addr[0], '0);
    drain();
    // the read is driven at a falling edge and accepted half a cycle later,
    // and rsp_valid is first sampled half a cycle after it rises
    lat = rsp_cycle - c0 - 1;
    assert (lat == 3) else begin
      $display("MISMATCH at %0t: read latency %0d cycles, expected 3", $time, lat);
      errors++;
    end
    report_test("read_latency", e0);
  endtask

  task automatic test_credit_flow();
    int e0;
    e0 = errors;
    drain();
    // a full burst goes out first and the rest only as credits come back
    for (int i = 0; i < N_BURST; i++) begin
      send(OP_READ, used_addr[$urandom % used_addr.size()], '0);
    end
    drain();
    assert (credits == REQ_DEPTH) else begin
      $display("MISMATCH at %0t: host holds %0d credits when idle, expected %0d",
               $time, credits, REQ_DEPTH);
      errors++;
    end
    report_test("credit_flow", e0);
  endtask

  // ------------------------------------------------------------
  // main sequence and watchdog
  // ------------------------------------------------------------

  initial begin
    void'($urandom(9));
    rst           = 1'b1;
    req_valid     = 1'b0;
    req_op        = OP_READ;
    req_addr      = '0;
    req_wdata     = '0;
    cfg_errinj_sb = 1'b0;
    cfg_errinj_mb = 1'b0;
    credits       = REQ_DEPTH;
    cycle         = 0;
    rsp_cycle     = 0;
    errors        = 0;
    tests_failed  = 0;
    repeat (RST_CYCLES) @(negedge clk);
    rst = 1'b0;
    test_round_trip();
    test_inject(1'b0);
    test_inject(1'b1);
    test_latency();
    test_credit_flow();
    $display("tests run 5, tests failed %0d, checks failed %0d", tests_failed, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    #(RUN_CYCLES * MARGIN * CLK_NS);
    $display("ERROR at %0t: watchdog expired before the tests finished", $time);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

/* compile.f */
rtl/ecc_pkg.sv
rtl/mem_port_if.sv
rtl/ecc_gen.sv
rtl/ecc_check.sv
rtl/ecc_wrap.sv
rtl/ecc_sram.sv
rtl/ecc_mem_bank.sv
rtl/ecc_mem_ctrl.sv
rtl/ecc_mem_top.sv
verif/tb_clkgen.sv
verif/tb_ecc_mem.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       := tb_ecc_mem
FILELIST  := compile.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status comes from the search for the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)
